/* Makefile */
# Verilator build and run for the DSMC local-bus slave testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* adc_sample_bank.sv */
// ADC sample bank: stores one set of eight channel samples and answers window reads
`timescale 1ns/10ps
`include "dsmc_settings.svh"

module adc_sample_bank (
    input  logic                 dsmc_clk_single,
    input  dsmc_pkg::sample_t    adc_data,
    input  logic                 adc_strobe,
    input  logic                 adc_first,
    input  logic                 wr_en,
    input  dsmc_pkg::word_addr_t wr_addr,
    input  dsmc_pkg::word_addr_t rd_addr,
    output logic                 win_hit,
    output dsmc_pkg::bus_word_t  win_data
);

    localparam dsmc_pkg::word_addr_t WIN_BASE  = dsmc_pkg::word_addr_t'(`DSMC_ADC_BASE);
    localparam dsmc_pkg::chan_idx_t  LAST_CHAN = dsmc_pkg::chan_idx_t'(`DSMC_CHANNELS - 1);

    dsmc_pkg::sample_t    samples [0:`DSMC_CHANNELS-1];
    dsmc_pkg::chan_idx_t  chan_idx;
    dsmc_pkg::chan_idx_t  slot;
    dsmc_pkg::chan_idx_t  hi_chan;
    dsmc_pkg::word_addr_t win_off;
    logic                 armed;
    logic                 take;
    logic                 set_done;
    logic                 status_wr;
    logic                 fresh;

    // ------------------------------------------------------------------------
    // Sample capture
    // ------------------------------------------------------------------------
    // adc_first restarts at channel 1, stray strobes outside a set are dropped
    assign slot      = adc_first ? '0 : chan_idx;
    assign take      = adc_strobe && (adc_first || armed);
    assign set_done  = take && (slot == LAST_CHAN);
    // Status word is the last window word
    assign status_wr = wr_en && (wr_addr == WIN_BASE + dsmc_pkg::word_addr_t'(4));

    always_ff @(posedge dsmc_clk_single) begin
        if (take) begin
            samples[slot] <= adc_data;
            chan_idx      <= dsmc_pkg::chan_idx_t'(slot + 1'b1);
            armed         <= !set_done;
        end
        // A new set outranks a clear in the same cycle
        if (set_done) begin
            fresh <= 1'b1;
        end else if (status_wr) begin
            fresh <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Window read, aligned with the RAM read
    // ------------------------------------------------------------------------
    assign win_off = dsmc_pkg::word_addr_t'(rd_addr - WIN_BASE);
    // Pair word k holds channels 2k+2 high and 2k+1 low
    assign hi_chan = {win_off[1:0], 1'b1};

    always_ff @(posedge dsmc_clk_single) begin
        win_hit <= (win_off < dsmc_pkg::word_addr_t'(`DSMC_ADC_WORDS));
        if (win_off == dsmc_pkg::word_addr_t'(4)) begin
            win_data <= {{(`DSMC_WORD_W-1){1'b0}}, fresh};
        end else begin
            win_data <= {samples[hi_chan], samples[hi_chan - 1'b1]};
        end
    end

    // Channels 2 to 8 only arrive inside a set opened by adc_first
    a_no_overrun : assert property (
        @(posedge dsmc_clk_single)
        (adc_strobe && !adc_first) |-> armed
    );

endmodule

/* dsmc_burst_decoder.sv */
// DSMC burst decoder: counts burst cycles and captures the command and start address
`timescale 1ns/10ps
`include "dsmc_settings.svh"

module dsmc_burst_decoder (
    input  logic                dsmc_clk_single,
    input  logic                cs_n,
    input  dsmc_pkg::bus_word_t dq_in,
    dsmc_burst_if.decoder       burst
);

    dsmc_pkg::cycle_cnt_t   cnt;
    dsmc_pkg::burst_phase_t phase;
    logic                   is_write;
    dsmc_pkg::word_addr_t   start_addr;

    // ------------------------------------------------------------------------
    // Cycle counter
    // ------------------------------------------------------------------------
    // Cleared while cs_n is low, first edge after cs_n rises is count 0
    // Holds at all ones so a long data phase stays a data phase
    always_ff @(posedge dsmc_clk_single or negedge cs_n) begin
        if (!cs_n) begin
            cnt <= '0;
        end else if (cnt != '1) begin
            cnt <= dsmc_pkg::cycle_cnt_t'(cnt + 1'b1);
        end
    end

    // Phase straight from the count
    always_comb begin
        if (cnt < dsmc_pkg::cycle_cnt_t'(`DSMC_CNT_ADDR_HI)) begin
            phase = dsmc_pkg::PH_CMD;
        end else if (cnt == dsmc_pkg::cycle_cnt_t'(`DSMC_CNT_ADDR_HI)) begin
            phase = dsmc_pkg::PH_ADDR_HI;
        end else if (cnt == dsmc_pkg::cycle_cnt_t'(`DSMC_CNT_ADDR_LO)) begin
            phase = dsmc_pkg::PH_ADDR_LO;
        end else if (cnt == dsmc_pkg::cycle_cnt_t'(`DSMC_CNT_SETUP)) begin
            phase = dsmc_pkg::PH_SETUP;
        end else begin
            phase = dsmc_pkg::PH_DATA;
        end
    end

    // ------------------------------------------------------------------------
    // Command and address capture
    // ------------------------------------------------------------------------
    // Command word on bits 15..0, bit 15 selects write
    always_ff @(posedge dsmc_clk_single or negedge cs_n) begin
        if (!cs_n) begin
            is_write <= 1'b0;
        end else if (cnt == dsmc_pkg::cycle_cnt_t'(`DSMC_CNT_CMD)) begin
            is_write <= dq_in[15];
        end
    end

    // Low address half carries byte address 15..0
    // Upper half lies beyond the RAM and is not kept
    always_ff @(posedge dsmc_clk_single) begin
        if (cnt == dsmc_pkg::cycle_cnt_t'(`DSMC_CNT_ADDR_LO)) begin
            start_addr <= dq_in[`DSMC_ADDR_W+1:2];
        end
    end

    // ------------------------------------------------------------------------
    // Burst interface
    // ------------------------------------------------------------------------
    assign burst.phase      = phase;
    assign burst.is_write   = is_write;
    assign burst.start_addr = start_addr;
    // Word number within the data phase, 0 before it
    assign burst.data_index = (cnt >= dsmc_pkg::cycle_cnt_t'(`DSMC_CNT_DATA)) ?
                              dsmc_pkg::cycle_cnt_t'(cnt - `DSMC_CNT_DATA) : '0;

    // Once in the data phase, the burst stays there until cs_n drops
    a_data_phase_holds : assert property (
        @(posedge dsmc_clk_single) disable iff (!cs_n)
        (phase == dsmc_pkg::PH_DATA) |=> (phase == dsmc_pkg::PH_DATA)
    );

endmodule

/* dsmc_burst_if.sv */
// Decoded burst state passed from the DSMC decoder to the write and read ports
`timescale 1ns/10ps

interface dsmc_burst_if;

    // Current phase of the burst
    dsmc_pkg::burst_phase_t phase;

    // Command bit 15, set for a write burst
    logic                   is_write;

    // First word address of the burst
    dsmc_pkg::word_addr_t   start_addr;

    // Data word number, 0 at the first data cycle
    dsmc_pkg::cycle_cnt_t   data_index;

    // Decoder side
    modport decoder (
        output phase,
        output is_write,
        output start_addr,
        output data_index
    );

    // Write and read ports
    modport port (
        input  phase,
        input  is_write,
        input  start_addr,
        input  data_index
    );

endinterface

/* dsmc_localbus_top.sv */
// DSMC local-bus slave top level: burst decoder, write and read ports, word RAM and ADC bank
`timescale 1ns/10ps
`include "dsmc_settings.svh"

module dsmc_localbus_top (
    // Bus side
    input  logic                dsmc_clk_single,
    input  logic                cs_n,
    input  dsmc_pkg::bus_word_t dq_in,
    output dsmc_pkg::bus_word_t dq_out,
    output logic                dq_oe,
    output logic                dqs_oe,
    // ADC sample side
    input  dsmc_pkg::sample_t   adc_data,
    input  logic                adc_strobe,
    input  logic                adc_first
);

    // RAM write channel
    logic                 wr_en;
    dsmc_pkg::word_addr_t wr_addr;
    dsmc_pkg::bus_word_t  wr_data;

    // Read side
    dsmc_pkg::word_addr_t rd_addr;
    dsmc_pkg::bus_word_t  ram_data;
    logic                 win_hit;
    dsmc_pkg::bus_word_t  win_data;

    // Decoded burst state
    dsmc_burst_if burst ();

    // ------------------------------------------------------------------------
    // Bus front end
    // ------------------------------------------------------------------------
    dsmc_burst_decoder u_decoder (
        .dsmc_clk_single (dsmc_clk_single),
        .cs_n            (cs_n),
        .dq_in           (dq_in),
        .burst           (burst.decoder)
    );

    dsmc_write_port u_write_port (
        .dsmc_clk_single (dsmc_clk_single),
        .cs_n            (cs_n),
        .dq_in           (dq_in),
        .burst           (burst.port),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data)
    );

    dsmc_read_port u_read_port (
        .dsmc_clk_single (dsmc_clk_single),
        .cs_n            (cs_n),
        .burst           (burst.port),
        .rd_addr         (rd_addr),
        .ram_data        (ram_data),
        .win_hit         (win_hit),
        .win_data        (win_data),
        .dq_out          (dq_out),
        .dq_oe           (dq_oe),
        .dqs_oe          (dqs_oe)
    );

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    word_ram #(
        .DATA_W (`DSMC_WORD_W),
        .ADDR_W (`DSMC_ADDR_W)
    ) u_word_ram (
        .clk     (dsmc_clk_single),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (ram_data)
    );

    // Snoops the write channel for status clears
    adc_sample_bank u_adc_bank (
        .dsmc_clk_single (dsmc_clk_single),
        .adc_data        (adc_data),
        .adc_strobe      (adc_strobe),
        .adc_first       (adc_first),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .rd_addr         (rd_addr),
        .win_hit         (win_hit),
        .win_data        (win_data)
    );

endmodule

/* dsmc_pkg.sv */
// DSMC local-bus types shared by the decoder, the data ports and the ADC bank
`include "dsmc_settings.svh"

package dsmc_pkg;

    // One bus data word
    typedef logic [`DSMC_WORD_W-1:0] bus_word_t;

    // RAM word address, byte address bits 15..2
    typedef logic [`DSMC_ADDR_W-1:0] word_addr_t;

    // One ADC channel sample
    typedef logic [`DSMC_SAMPLE_W-1:0] sample_t;

    // Channel number, 0 is channel 1
    typedef logic [$clog2(`DSMC_CHANNELS)-1:0] chan_idx_t;

    // Burst cycle counter, saturates at all ones
    typedef logic [7:0] cycle_cnt_t;

    // Burst phases in bus order
    typedef enum logic [2:0] {
        PH_CMD,
        PH_ADDR_HI,
        PH_ADDR_LO,
        PH_SETUP,
        PH_DATA
    } burst_phase_t;

endpackage

/* dsmc_read_port.sv */
// DSMC read port: steps the read address, picks RAM or ADC window data, drives the enables
`timescale 1ns/10ps

module dsmc_read_port (
    input  logic                 dsmc_clk_single,
    input  logic                 cs_n,
    dsmc_burst_if.port           burst,
    output dsmc_pkg::word_addr_t rd_addr,
    input  dsmc_pkg::bus_word_t  ram_data,
    input  logic                 win_hit,
    input  dsmc_pkg::bus_word_t  win_data,
    output dsmc_pkg::bus_word_t  dq_out,
    output logic                 dq_oe,
    output logic                 dqs_oe
);

    logic is_read_data;

    assign is_read_data = !burst.is_write && (burst.phase == dsmc_pkg::PH_DATA);

    // ------------------------------------------------------------------------
    // Read address
    // ------------------------------------------------------------------------
    // Start address in setup, then one step per data cycle
    always_ff @(posedge dsmc_clk_single) begin
        if (burst.phase == dsmc_pkg::PH_SETUP) begin
            rd_addr <= burst.start_addr;
        end else if (is_read_data) begin
            rd_addr <= dsmc_pkg::word_addr_t'(rd_addr + 1'b1);
        end
    end

    // ------------------------------------------------------------------------
    // Output word
    // ------------------------------------------------------------------------
    // RAM and window data both land one edge after rd_addr
    // Window words override the RAM contents
    always_ff @(posedge dsmc_clk_single) begin
        dq_out <= win_hit ? win_data : ram_data;
    end

    // Pipeline is rd_addr, RAM read, dq_out
    // First word for start is on dq_out after the data index 1 edge
    always_ff @(posedge dsmc_clk_single or negedge cs_n) begin
        if (!cs_n) begin
            dq_oe <= 1'b0;
        end else begin
            dq_oe <= is_read_data && (burst.data_index >= dsmc_pkg::cycle_cnt_t'(1));
        end
    end

    // Strobe driver enable from count 9 of a read burst
    assign dqs_oe = is_read_data && (burst.data_index >= dsmc_pkg::cycle_cnt_t'(3));

endmodule

/* dsmc_settings.svh */
// DSMC local-bus slave settings: bus widths, ADC window placement and burst count points
`ifndef DSMC_SETTINGS_SVH
`define DSMC_SETTINGS_SVH

// ------------------------------------------------------------------------
// Data path widths
// ------------------------------------------------------------------------
`define DSMC_WORD_W      32
// Word address into the 16k-word RAM
`define DSMC_ADDR_W      14
`define DSMC_SAMPLE_W    16
`define DSMC_CHANNELS    8

// ------------------------------------------------------------------------
// ADC read-back window, word addresses
// ------------------------------------------------------------------------
// Four channel-pair words, then the status word
`define DSMC_ADC_BASE    'h3F8
`define DSMC_ADC_WORDS   5

// ------------------------------------------------------------------------
// Burst cycle counts, counted from the first edge after cs_n rises
// ------------------------------------------------------------------------
`define DSMC_CNT_CMD     2
`define DSMC_CNT_ADDR_HI 3
`define DSMC_CNT_ADDR_LO 4
`define DSMC_CNT_SETUP   5
`define DSMC_CNT_DATA    6

`endif

/* dsmc_write_port.sv */
// DSMC write port: turns data-phase bus words into sequential RAM writes
`timescale 1ns/10ps

module dsmc_write_port (
    input  logic                 dsmc_clk_single,
    input  logic                 cs_n,
    input  dsmc_pkg::bus_word_t  dq_in,
    dsmc_burst_if.port           burst,
    output logic                 wr_en,
    output dsmc_pkg::word_addr_t wr_addr,
    output dsmc_pkg::bus_word_t  wr_data
);

    dsmc_pkg::word_addr_t next_addr;
    logic                 take_word;

    // One word per data cycle of a write burst
    assign take_word = burst.is_write && (burst.phase == dsmc_pkg::PH_DATA);

    // Write strobe, one cycle per word
    always_ff @(posedge dsmc_clk_single or negedge cs_n) begin
        if (!cs_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= take_word;
        end
    end

    // ------------------------------------------------------------------------
    // Address stepping and data register
    // ------------------------------------------------------------------------
    // Loaded in setup, word n of the data phase goes to start + n
    always_ff @(posedge dsmc_clk_single) begin
        if (burst.phase == dsmc_pkg::PH_SETUP) begin
            next_addr <= burst.start_addr;
        end else if (take_word) begin
            wr_addr   <= next_addr;
            wr_data   <= dq_in;
            next_addr <= dsmc_pkg::word_addr_t'(next_addr + 1'b1);
        end
    end

    // The command bit is latched before the data phase, so a read burst never writes
    a_no_write_on_read : assert property (
        @(posedge dsmc_clk_single) disable iff (!cs_n)
        $rose(wr_en) |-> burst.is_write
    );

endmodule

/* tb.f */
+incdir+.
dsmc_pkg.sv
dsmc_burst_if.sv
dsmc_burst_decoder.sv
dsmc_write_port.sv
dsmc_read_port.sv
word_ram.sv
adc_sample_bank.sv
dsmc_localbus_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

/* tb_checker.sv */
// Testbench checker: collects read words from the DSMC slave and compares them in order
`timescale 1ns/10ps

module tb_checker (
    input logic                clk,
    input logic                cs_n,
    input logic                wr_burst,
    input dsmc_pkg::bus_word_t dq_out,
    input logic                dq_oe,
    input logic                dqs_oe
);

    // Strobe driver enable turns on at this count of a read burst
    localparam int DQS_START = 9;

    dsmc_pkg::bus_word_t expect_q [$];
    dsmc_pkg::cycle_cnt_t cyc;
    logic dqs_exp;
    int got_count   = 0;
    int err_count   = 0;
    int row_errs    = 0;
    int rows_run    = 0;
    int rows_failed = 0;

    // Queue one expected read word
    function automatic void expect_word(input dsmc_pkg::bus_word_t w);
        expect_q.push_back(w);
    endfunction

    function automatic void start_row();
        row_errs = 0;
        expect_q.delete();
    endfunction

    // One result line per table row
    function automatic void finish_row(input int row, input string what);
        if (expect_q.size() != 0) begin
            $display("Row %0d: %0d read words never showed up on dq_out", row, expect_q.size());
            row_errs++;
            err_count++;
        end
        rows_run++;
        if (row_errs != 0) begin
            rows_failed++;
            $display("row %0d %s: FAIL, %0d errors", row, what, row_errs);
        end else begin
            $display("row %0d %s: ok", row, what);
        end
    endfunction

    // ------------------------------------------------------------------------
    // Bus cycle count
    // ------------------------------------------------------------------------
    // 0 until the first edge after cs_n rises, holds at all ones
    always @(posedge clk or negedge cs_n) begin
        if (!cs_n) begin
            cyc <= '0;
        end else if (cyc != 8'hFF) begin
            cyc <= dsmc_pkg::cycle_cnt_t'(cyc + 8'd1);
        end
    end

    // ------------------------------------------------------------------------
    // Sampling on the falling edge, away from DUT and driver updates
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        // Enables only belong to read bursts
        if ((dq_oe || dqs_oe) && (!cs_n || wr_burst)) begin
            $display("Output enable high at %0t outside a read burst", $time);
            err_count++;
            row_errs++;
        end
        // Inside a read burst the strobe enable follows the cycle count
        if (cs_n && !wr_burst) begin
            dqs_exp = (int'(cyc) >= DQS_START);
            if (dqs_oe !== dqs_exp) begin
                $display("[FAIL] t=%0t dqs_oe expected %0b actual %0b",
                         $time, dqs_exp, dqs_oe);
                err_count++;
                row_errs++;
            end
        end
        if (cs_n && dq_oe) begin
            if (expect_q.size() == 0) begin
                $display("dq_oe high at %0t but no read word was expected", $time);
                err_count++;
                row_errs++;
            end else begin
                got_count++;
                if (dq_out !== expect_q[0]) begin
                    $display("[FAIL] t=%0t dq_out expected %08h actual %08h",
                             $time, expect_q[0], dq_out);
                    err_count++;
                    row_errs++;
                end
                void'(expect_q.pop_front());
            end
        end
    end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and power-on reset source for the DSMC slave
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    // 100 ns bus clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held low for the first cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5 rst_n = 1'b1;
    end

endmodule

/* tb_top.sv */
// Testbench top for the DSMC local-bus slave: table-driven bursts and ADC sample sets
`timescale 1ns/10ps
`include "dsmc_settings.svh"

module tb_top;

    localparam int OP_WR   = 0;
    localparam int OP_RD   = 1;
    localparam int OP_ADC  = 2;
    localparam int OP_RWR  = 3;
    localparam int ROWS    = 14;
    localparam int TIMEOUT = 20;
    localparam logic [13:0] BASE = 14'(`DSMC_ADC_BASE);

    // ------------------------------------------------------------------------
    // Stimulus table, one row per test: operation, word address, length
    // ------------------------------------------------------------------------
    localparam logic [31:0] STIM [0:ROWS-1] = '{
        {8'd0, 16'h0010, 8'd4},
        {8'd1, 16'h0010, 8'd4},
        {8'd3, 16'h0000, 8'd1},
        {8'd3, 16'h0000, 8'd1},
        {8'd3, 16'h0000, 8'd1},
        {8'd1, 16'h0010, 8'd4},
        {8'd2, 16'h0000, 8'd8},
        {8'd1, 16'(`DSMC_ADC_BASE), 8'd5},
        {8'd0, 16'(`DSMC_ADC_BASE + 4), 8'd1},
        {8'd1, 16'(`DSMC_ADC_BASE + 4), 8'd1},
        {8'd2, 16'h0000, 8'd8},
        {8'd1, 16'(`DSMC_ADC_BASE + 4), 8'd1},
        {8'd0, 16'(`DSMC_ADC_BASE), 8'd4},
        {8'd1, 16'(`DSMC_ADC_BASE), 8'd5}
    };

    logic                clk;
    logic                rst_n;
    logic                bus_cs;
    logic                cs_n;
    logic                wr_burst;
    dsmc_pkg::bus_word_t dq_in;
    dsmc_pkg::bus_word_t dq_out;
    logic                dq_oe;
    logic                dqs_oe;
    dsmc_pkg::sample_t   adc_data;
    logic                adc_strobe;
    logic                adc_first;

    // Reference model of what the bus should read back
    integer              seed;
    logic [31:0]         model_ram [int];
    logic [15:0]         model_smp [0:7];
    logic                model_fresh;
    logic                timed_out;

    // Chip select also carries the power-on reset
    assign cs_n = rst_n & bus_cs;

    tb_clock_gen clk_gen (.clk(clk), .rst_n(rst_n));

    dsmc_localbus_top dut (
        .dsmc_clk_single (clk),
        .cs_n            (cs_n),
        .dq_in           (dq_in),
        .dq_out          (dq_out),
        .dq_oe           (dq_oe),
        .dqs_oe          (dqs_oe),
        .adc_data        (adc_data),
        .adc_strobe      (adc_strobe),
        .adc_first       (adc_first)
    );

    tb_checker chk (
        .clk      (clk),
        .cs_n     (cs_n),
        .wr_burst (wr_burst),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe),
        .dqs_oe   (dqs_oe)
    );

    function automatic string op_name(input int op);
        case (op)
            OP_WR:   return "write burst";
            OP_RD:   return "read burst";
            OP_ADC:  return "ADC set";
            default: return "random write and read";
        endcase
    endfunction

    // Window pairs put the higher channel in the upper half, status in bit 0
    function automatic logic [31:0] model_word(input logic [13:0] a);
        int k;
        k = int'(a - BASE);
        if (a >= BASE && a < BASE + 14'd4) begin
            return {model_smp[2*k+1], model_smp[2*k]};
        end else if (a == BASE + 14'd4) begin
            return {31'b0, model_fresh};
        end
        return model_ram[int'(a)];
    endfunction

    // Drive dq_in shortly after the next rising edge
    task automatic bus_cycle(input logic [31:0] w);
        @(posedge clk);
        #5 dq_in = w;
    endtask

    // cs_n rises, then command, address halves and the setup cycle
    task automatic open_burst(input logic wr, input logic [13:0] a);
        @(posedge clk);
        #5;
        wr_burst = wr;
        bus_cs   = 1'b1;
        dq_in    = '0;
        bus_cycle(32'h0);
        bus_cycle(wr ? 32'h0000_8000 : 32'h0);
        bus_cycle(32'h0);
        bus_cycle({16'h0, a, 2'b00});
        bus_cycle(32'h0);
    endtask

    task automatic write_burst(input logic [13:0] a, input int n);
        logic [31:0] w;
        logic [13:0] wa;
        open_burst(1'b1, a);
        for (int k = 0; k < n; k++) begin
            w  = $random(seed);
            wa = a + 14'(k);
            if (wa == BASE + 14'd4) begin
                model_fresh = 1'b0;
            end else if (!(wa >= BASE && wa < BASE + 14'd4)) begin
                model_ram[int'(wa)] = w;
            end
            bus_cycle(w);
        end
        // Two idle cycles let the last word reach the RAM
        bus_cycle(32'h0);
        bus_cycle(32'h0);
        bus_cs   = 1'b0;
        wr_burst = 1'b0;
    endtask

    // Clocks the burst until the checker has taken every word
    task automatic read_burst(input logic [13:0] a, input int n);
        int target;
        int waited;
        target = chk.got_count + n;
        waited = 0;
        for (int k = 0; k < n; k++) begin
            chk.expect_word(model_word(a + 14'(k)));
        end
        open_burst(1'b0, a);
        while (chk.got_count < target && waited < n + TIMEOUT) begin
            bus_cycle(32'h0);
            waited++;
        end
        if (chk.got_count < target) begin
            $display("Timeout at %0t: dq_oe delivered %0d of %0d words from %h",
                     $time, n - (target - chk.got_count), n, a);
            timed_out = 1'b1;
        end
        bus_cs = 1'b0;
    endtask

    // Eight strobes on consecutive cycles, channel 1 marked
    task automatic adc_set();
        logic [15:0] s;
        for (int i = 0; i < 8; i++) begin
            s = 16'($random(seed));
            model_smp[i] = s;
            @(posedge clk);
            #5;
            adc_strobe = 1'b1;
            adc_first  = (i == 0);
            adc_data   = s;
        end
        @(posedge clk);
        #5;
        adc_strobe  = 1'b0;
        adc_first   = 1'b0;
        model_fresh = 1'b1;
    endtask

    task automatic run_row(input int r);
        int          op;
        logic [13:0] a;
        int          n;
        op = int'(STIM[r][31:24]);
        a  = STIM[r][21:8];
        n  = int'(STIM[r][7:0]);
        chk.start_row();
        case (op)
            OP_WR:  write_burst(a, n);
            OP_RD:  read_burst(a, n);
            OP_ADC: adc_set();
            OP_RWR: begin
                // Above the first burst and the ADC window
                a = 14'h0400 + 14'($unsigned($random(seed)) % 32'h3C00);
                write_burst(a, 1);
                read_burst(a, 1);
            end
        endcase
        chk.finish_row(r, op_name(op));
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        seed        = 32'hc63d2e6e;
        bus_cs      = 1'b0;
        wr_burst    = 1'b0;
        dq_in       = '0;
        adc_data    = '0;
        adc_strobe  = 1'b0;
        adc_first   = 1'b0;
        model_fresh = 1'b0;
        timed_out   = 1'b0;
        for (int i = 0; i < TIMEOUT && !rst_n; i++) begin
            @(posedge clk);
        end
        if (!rst_n) begin
            $display("Timeout at %0t: reset was never released", $time);
            timed_out = 1'b1;
        end
        for (int r = 0; r < ROWS && !timed_out; r++) begin
            run_row(r);
        end
        repeat (2) @(posedge clk);
        $display("Rows run %0d, rows failed %0d, errors %0d, words read %0d",
                 chk.rows_run, chk.rows_failed, chk.err_count, chk.got_count);
        if (!timed_out && chk.rows_failed == 0 && chk.err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* word_ram.sv */
// Simple dual-port word RAM with one write port and a registered read port
`timescale 1ns/10ps

module word_ram #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 14
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    // 2**ADDR_W words, 16k for the bus
    logic [DATA_W-1:0] mem [0:(2**ADDR_W)-1];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read every cycle, data one edge after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule
